/* noc_mesh_4x4.f */
rtl/noc_flit_pkg.sv
rtl/noc_topo_pkg.sv
rtl/xy_route_split.sv
rtl/port_arbiter.sv
rtl/mesh_router.sv
rtl/noc_mesh_4x4.sv
verif/noc_mesh_checker.sv
verif/noc_mesh_4x4_tb.sv

/* Bender.yml */
package:
  name: noc_mesh_4x4

sources:
  # packages first, then the router parts bottom up
  - files:
      - rtl/noc_flit_pkg.sv
      - rtl/noc_topo_pkg.sv
      - rtl/xy_route_split.sv
      - rtl/port_arbiter.sv
      - rtl/mesh_router.sv
      - rtl/noc_mesh_4x4.sv

  # testbench, top module noc_mesh_4x4_tb
  - target: test
    files:
      - verif/noc_mesh_checker.sv
      - verif/noc_mesh_4x4_tb.sv

/* verif/noc_mesh_4x4_tb.sv */
module noc_mesh_4x4_tb;

  timeunit 1ns;
  timeprecision 100ps;

  // test phases, run one after another with a drain in between
  typedef enum int {
    ph_local,
    ph_xy,
    ph_order,
    ph_burst,
    ph_bp,
    ph_end
  } phase_e;

  // one row of the stimulus table
  typedef struct packed {
    phase_e              phase;
    logic [3:0]          src;
    noc_flit_pkg::flit_t flit;
  } stim_t;

  logic                               clk = 1'b0;
  logic                               rst_n;
  noc_flit_pkg::link_t                pe_in [noc_topo_pkg::num_nodes];
  logic [noc_topo_pkg::num_nodes-1:0] pe_in_ready;
  noc_flit_pkg::link_t                pe_out [noc_topo_pkg::num_nodes];
  logic [noc_topo_pkg::num_nodes-1:0] pe_out_ready;

  int    pending;
  int    value_errs;
  int    route_errs;
  int    proto_errs;
  stim_t tbl [$];
  bit    tbl_ready = 1'b0;
  bit    bp_on = 1'b0;      // random pe_out_ready while set

  noc_mesh_4x4 dut0 (
    .clk          (clk),
    .rst_n        (rst_n),
    .pe_in        (pe_in),
    .pe_out_ready (pe_out_ready),
    .pe_in_ready  (pe_in_ready),
    .pe_out       (pe_out)
  );

  noc_mesh_checker chk0 (
    .clk          (clk),
    .rst_n        (rst_n),
    .pe_in        (pe_in),
    .pe_in_ready  (pe_in_ready),
    .pe_out       (pe_out),
    .pe_out_ready (pe_out_ready),
    .pending      (pending),
    .value_errs   (value_errs),
    .route_errs   (route_errs),
    .proto_errs   (proto_errs)
  );

  initial begin
    forever #4 clk = ~clk;
  end

  // payload carries the source node on top and a unique sequence number below
  function automatic void add_entry(input phase_e ph, input int src, input int dst);
    stim_t e;
    int    seq;
    seq            = tbl.size();
    e.phase        = ph;
    e.src          = src[3:0];
    e.flit.dst_x   = noc_topo_pkg::node_x(dst);
    e.flit.dst_y   = noc_topo_pkg::node_y(dst);
    e.flit.payload = {src[3:0], seq[23:0]};
    tbl.push_back(e);
  endfunction

  function automatic void build_table();
    for (int n = 0; n < noc_topo_pkg::num_nodes; n++) begin
      add_entry(ph_local, n, n);   // every node to itself
    end
    for (int n = 0; n < noc_topo_pkg::num_nodes; n++) begin
      add_entry(ph_xy, n, (n * 7 + 3) % noc_topo_pkg::num_nodes);
    end
    add_entry(ph_xy, 0, 15);       // corner to corner, both diagonals
    add_entry(ph_xy, 15, 0);
    add_entry(ph_xy, 3, 12);
    add_entry(ph_xy, 12, 3);
    for (int i = 0; i < 8; i++) begin
      add_entry(ph_order, 2, 13);
    end
    // everybody hammers node 5
    for (int i = 0; i < 4; i++) begin
      for (int n = 0; n < noc_topo_pkg::num_nodes; n++) begin
        add_entry(ph_burst, n, 5);
      end
    end
    for (int i = 0; i < 3; i++) begin
      for (int n = 0; n < noc_topo_pkg::num_nodes; n++) begin
        add_entry(ph_bp, n, (n * 5 + i * 3 + 1) % noc_topo_pkg::num_nodes);
      end
    end
  endfunction

  // walks the table in order, sending this node's rows of one phase
  task automatic inject(input int node, input phase_e ph);
    for (int i = 0; i < tbl.size(); i++) begin
      if (int'(tbl[i].src) == node && tbl[i].phase == ph) begin
        @(negedge clk);
        pe_in[node].valid = 1'b1;
        pe_in[node].flit  = tbl[i].flit;
        @(posedge clk);
        while (!pe_in_ready[node]) begin
          @(posedge clk);
        end
      end
    end
    @(negedge clk);
    pe_in[node] = '0;
  endtask

  initial begin : ready_drive
    void'($urandom(29012));
    pe_out_ready = '1;
    forever begin
      @(negedge clk);
      for (int n = 0; n < noc_topo_pkg::num_nodes; n++) begin
        pe_out_ready[n] = bp_on ? (($urandom % 3) != 0) : 1'b1;   // low about 1 in 3
      end
    end
  end

  initial begin : watchdog
    int limit;
    wait (tbl_ready);
    limit = tbl.size() * 64 + 10;
    repeat (limit) @(posedge clk);
    $display("timeout: run did not end within %0d cycles, %0d flits still in flight",
             limit, pending);
    $display("CHECKS FAILED");
    $finish;
  end

  initial begin : main
    int total;
    for (int n = 0; n < noc_topo_pkg::num_nodes; n++) begin
      pe_in[n] = '0;
    end
    rst_n = 1'b0;
    build_table();
    tbl_ready = 1'b1;
    repeat (10) @(negedge clk);
    rst_n = 1'b1;
    repeat (2) @(negedge clk);   // reset state is sampled by chk0 here

    for (int ph = 0; ph < int'(ph_end); ph++) begin
      bp_on = (ph == int'(ph_bp));
      for (int n = 0; n < noc_topo_pkg::num_nodes; n++) begin
        fork
          automatic int node = n;
          inject(node, phase_e'(ph));
        join_none
      end
      wait fork;
      wait (pending == 0);   // whole phase delivered
      bp_on = 1'b0;
      repeat (4) @(negedge clk);
    end

    total = value_errs + route_errs + proto_errs + pending;
    $display("errors: value %0d, routing %0d, protocol %0d, flits left %0d",
             value_errs, route_errs, proto_errs, pending);
    if (total == 0) begin
      $display("ALL CHECKS PASSED");
    end else begin
      $display("CHECKS FAILED");
    end
    $finish;
  end

endmodule

/* verif/noc_mesh_checker.sv */
module noc_mesh_checker (
  input  logic                               clk,
  input  logic                               rst_n,
  input  noc_flit_pkg::link_t                pe_in [noc_topo_pkg::num_nodes],
  input  logic [noc_topo_pkg::num_nodes-1:0] pe_in_ready,
  input  noc_flit_pkg::link_t                pe_out [noc_topo_pkg::num_nodes],
  input  logic [noc_topo_pkg::num_nodes-1:0] pe_out_ready,
  output int                                 pending,      // flits accepted, not yet out
  output int                                 value_errs,
  output int                                 route_errs,
  output int                                 proto_errs
);

  timeunit 1ns;
  timeprecision 100ps;

  // expected payloads, [source][destination], oldest first
  logic [noc_flit_pkg::payload_w-1:0] exp_q [noc_topo_pkg::num_nodes][noc_topo_pkg::num_nodes][$];

  noc_flit_pkg::link_t                last_out [noc_topo_pkg::num_nodes];
  logic [noc_topo_pkg::num_nodes-1:0] stalled;
  bit                                 reset_checked;

  // node whose coordinate matches, straight from the mesh numbering rule
  function automatic int node_at(input logic [1:0] x, input logic [1:0] y);
    int m;
    m = -1;
    for (int k = 0; k < noc_topo_pkg::num_nodes; k++) begin
      if (noc_topo_pkg::node_x(k) == x && noc_topo_pkg::node_y(k) == y) begin
        m = k;
      end
    end
    return m;
  endfunction

  always @(posedge clk) begin
    logic [3:0]                         src;
    int                                 d;
    logic [noc_flit_pkg::payload_w-1:0] exp_pl;
    if (!rst_n) begin
      pending       = 0;
      value_errs    = 0;
      route_errs    = 0;
      proto_errs    = 0;
      stalled       = '0;
      reset_checked = 1'b0;
    end else begin
      if (!reset_checked) begin
        reset_checked = 1'b1;
        for (int n = 0; n < noc_topo_pkg::num_nodes; n++) begin
          if (pe_out[n].valid || !pe_in_ready[n]) begin
            proto_errs++;
            $display("node %0d is not idle right after reset", n);
          end
        end
      end
      for (int n = 0; n < noc_topo_pkg::num_nodes; n++) begin
        if (pe_in[n].valid && pe_in_ready[n]) begin
          d = node_at(pe_in[n].flit.dst_x, pe_in[n].flit.dst_y);
          exp_q[n][d].push_back(pe_in[n].flit.payload);
          pending++;
        end
        if (stalled[n] && pe_out[n] !== last_out[n]) begin
          proto_errs++;
          $display("pe_out[%0d] changed while it was waiting for ready", n);
        end
        if (pe_out[n].valid && pe_out_ready[n]) begin
          if (pe_out[n].flit.dst_x !== noc_topo_pkg::node_x(n) ||
              pe_out[n].flit.dst_y !== noc_topo_pkg::node_y(n)) begin
            route_errs++;
            $display("error pe_out[%0d].flit.dst_x/dst_y: got 0x%h/0x%h, expected 0x%h/0x%h",
                     n, pe_out[n].flit.dst_x, pe_out[n].flit.dst_y,
                     noc_topo_pkg::node_x(n), noc_topo_pkg::node_y(n));
          end
          src = pe_out[n].flit.payload[27:24];   // source node sits on top of the payload
          d   = node_at(pe_out[n].flit.dst_x, pe_out[n].flit.dst_y);
          if (exp_q[src][d].size() == 0) begin
            proto_errs++;
            $display("flit 0x%h at pe_out[%0d] was never sent or arrived twice",
                     pe_out[n].flit, n);
          end else begin
            exp_pl = exp_q[src][d].pop_front();
            pending--;
            if (exp_pl !== pe_out[n].flit.payload) begin
              value_errs++;
              $display("error pe_out[%0d].flit.payload: got 0x%h, expected 0x%h",
                       n, pe_out[n].flit.payload, exp_pl);
            end
          end
        end
        stalled[n]  = pe_out[n].valid && !pe_out_ready[n];
        last_out[n] = pe_out[n];
      end
    end
  end

endmodule

/* rtl/noc_mesh_4x4.sv */
module noc_mesh_4x4 (
  input  logic                               clk,
  input  logic                               rst_n,
  input  noc_flit_pkg::link_t                pe_in [noc_topo_pkg::num_nodes],
  input  logic [noc_topo_pkg::num_nodes-1:0] pe_out_ready,
  output logic [noc_topo_pkg::num_nodes-1:0] pe_in_ready,
  output noc_flit_pkg::link_t                pe_out [noc_topo_pkg::num_nodes]
);

  // per router view, [node][direction]
  noc_flit_pkg::link_t rin  [noc_topo_pkg::num_nodes][noc_topo_pkg::num_ports];
  noc_flit_pkg::link_t rout [noc_topo_pkg::num_nodes][noc_topo_pkg::num_ports];
  logic [noc_topo_pkg::num_ports-1:0] rin_ready  [noc_topo_pkg::num_nodes];
  logic [noc_topo_pkg::num_ports-1:0] rout_ready [noc_topo_pkg::num_nodes];

  for (genvar n = 0; n < noc_topo_pkg::num_nodes; n++) begin : g_node
    localparam int x = noc_topo_pkg::node_x(n);
    localparam int y = noc_topo_pkg::node_y(n);

    mesh_router #(
      .x_loc(noc_topo_pkg::node_x(n)),
      .y_loc(noc_topo_pkg::node_y(n))
    ) u_router (
      .clk       (clk),
      .rst_n     (rst_n),
      .in_links  (rin[n]),
      .out_ready (rout_ready[n]),
      .in_ready  (rin_ready[n]),
      .out_links (rout[n])
    );

    // local pe port straight to the top level
    assign rin[n][noc_topo_pkg::port_pe]        = pe_in[n];
    assign pe_in_ready[n]                       = rin_ready[n][noc_topo_pkg::port_pe];
    assign pe_out[n]                            = rout[n][noc_topo_pkg::port_pe];
    assign rout_ready[n][noc_topo_pkg::port_pe] = pe_out_ready[n];

    // edge links stay idle, xy routing never sends a flit off the mesh
    if (x < noc_topo_pkg::mesh_dim - 1) begin : g_east
      assign rin[n][noc_topo_pkg::port_east]        = rout[n+1][noc_topo_pkg::port_west];
      assign rout_ready[n][noc_topo_pkg::port_east] = rin_ready[n+1][noc_topo_pkg::port_west];
    end else begin : g_east_edge
      assign rin[n][noc_topo_pkg::port_east]        = '0;
      assign rout_ready[n][noc_topo_pkg::port_east] = 1'b0;
    end

    if (x > 0) begin : g_west
      assign rin[n][noc_topo_pkg::port_west]        = rout[n-1][noc_topo_pkg::port_east];
      assign rout_ready[n][noc_topo_pkg::port_west] = rin_ready[n-1][noc_topo_pkg::port_east];
    end else begin : g_west_edge
      assign rin[n][noc_topo_pkg::port_west]        = '0;
      assign rout_ready[n][noc_topo_pkg::port_west] = 1'b0;
    end

    // north neighbour is one row up, index minus mesh_dim
    if (y < noc_topo_pkg::mesh_dim - 1) begin : g_north
      assign rin[n][noc_topo_pkg::port_north] =
        rout[n-noc_topo_pkg::mesh_dim][noc_topo_pkg::port_south];
      assign rout_ready[n][noc_topo_pkg::port_north] =
        rin_ready[n-noc_topo_pkg::mesh_dim][noc_topo_pkg::port_south];
    end else begin : g_north_edge
      assign rin[n][noc_topo_pkg::port_north]        = '0;
      assign rout_ready[n][noc_topo_pkg::port_north] = 1'b0;
    end

    if (y > 0) begin : g_south
      assign rin[n][noc_topo_pkg::port_south] =
        rout[n+noc_topo_pkg::mesh_dim][noc_topo_pkg::port_north];
      assign rout_ready[n][noc_topo_pkg::port_south] =
        rin_ready[n+noc_topo_pkg::mesh_dim][noc_topo_pkg::port_north];
    end else begin : g_south_edge
      assign rin[n][noc_topo_pkg::port_south]        = '0;
      assign rout_ready[n][noc_topo_pkg::port_south] = 1'b0;
    end
  end

endmodule

/* rtl/mesh_router.sv */
module mesh_router #(
  parameter logic [noc_flit_pkg::coord_w-1:0] x_loc = '0,
  parameter logic [noc_flit_pkg::coord_w-1:0] y_loc = '0
) (
  input  logic                               clk,
  input  logic                               rst_n,
  input  noc_flit_pkg::link_t                in_links [noc_topo_pkg::num_ports],
  input  logic [noc_topo_pkg::num_ports-1:0] out_ready,
  output logic [noc_topo_pkg::num_ports-1:0] in_ready,
  output noc_flit_pkg::link_t                out_links [noc_topo_pkg::num_ports]
);

  noc_flit_pkg::link_t                held        [noc_topo_pkg::num_ports];
  logic [noc_topo_pkg::num_ports-1:0] route_req   [noc_topo_pkg::num_ports];
  logic [noc_topo_pkg::num_ports-1:0] split_grant [noc_topo_pkg::num_ports];

  // one input buffer per direction, indexed pe, east, west, north, south
  for (genvar s = 0; s < noc_topo_pkg::num_ports; s++) begin : g_split
    xy_route_split #(
      .x_loc(x_loc),
      .y_loc(y_loc)
    ) u_split (
      .clk       (clk),
      .rst_n     (rst_n),
      .in_link   (in_links[s]),
      .grant     (split_grant[s]),
      .in_ready  (in_ready[s]),
      .held      (held[s]),
      .route_req (route_req[s])
    );
  end

  for (genvar o = 0; o < noc_topo_pkg::num_ports; o++) begin : g_out
    // the pe output also takes the pe split, so a node can address itself
    localparam int n_in = (o == noc_topo_pkg::port_pe) ?
                          noc_topo_pkg::num_ports : noc_topo_pkg::num_ports - 1;

    logic [n_in-1:0]     arb_req;
    logic [n_in-1:0]     arb_grant;
    noc_flit_pkg::link_t cand [n_in];

    for (genvar k = 0; k < n_in; k++) begin : g_cand
      // other outputs skip the split of their own direction
      localparam int s = (o == noc_topo_pkg::port_pe || k < o) ? k : k + 1;

      assign cand[k]           = held[s];
      assign arb_req[k]        = route_req[s][o];
      assign split_grant[s][o] = arb_grant[k];
    end

    if (o != noc_topo_pkg::port_pe) begin : g_no_uturn
      assign split_grant[o][o] = 1'b0;
    end

    port_arbiter #(
      .n_in(n_in)
    ) u_arb (
      .clk       (clk),
      .rst_n     (rst_n),
      .req       (arb_req),
      .cand      (cand),
      .out_ready (out_ready[o]),
      .out_link  (out_links[o]),
      .grant     (arb_grant)
    );
  end

endmodule

/* rtl/port_arbiter.sv */
module port_arbiter #(
  parameter int n_in = 4
) (
  input  logic                clk,
  input  logic                rst_n,
  input  logic [n_in-1:0]     req,
  input  noc_flit_pkg::link_t cand [n_in],
  input  logic                out_ready,
  output noc_flit_pkg::link_t out_link,
  output logic [n_in-1:0]     grant
);

  logic [$clog2(n_in)-1:0] ptr;        // first candidate looked at
  logic [$clog2(n_in)-1:0] win;
  logic [$clog2(n_in)-1:0] lock_idx;
  logic                    lock;       // stalled winner, kept until it moves
  logic                    found;
  logic                    xfer;

  // round robin search from ptr, skipped while a stalled choice is held
  always_comb begin
    int idx;
    idx   = 0;
    found = lock;
    win   = lock ? lock_idx : ptr;
    if (!lock) begin
      for (int i = 0; i < n_in; i++) begin
        idx = (int'(ptr) + i) % n_in;
        if (!found && req[idx]) begin
          found = 1'b1;
          win   = idx[$clog2(n_in)-1:0];
        end
      end
    end
  end

  assign xfer = found && out_ready;

  assign out_link.valid = found;
  assign out_link.flit  = cand[win].flit;

  always_comb begin
    grant = '0;
    if (xfer) begin
      grant[win] = 1'b1;   // the winner frees its buffer on this edge
    end
  end

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      ptr      <= '0;
      lock     <= 1'b0;
      lock_idx <= '0;
    end else if (xfer) begin
      ptr  <= (win == n_in - 1) ? '0 : win + 1'b1;   // one past the winner
      lock <= 1'b0;
    end else if (found) begin
      // output is stalled, keep the same flit on the link
      lock     <= 1'b1;
      lock_idx <= win;
    end
  end

endmodule

/* rtl/xy_route_split.sv */
module xy_route_split #(
  parameter logic [noc_flit_pkg::coord_w-1:0] x_loc = '0,
  parameter logic [noc_flit_pkg::coord_w-1:0] y_loc = '0
) (
  input  logic                               clk,
  input  logic                               rst_n,
  input  noc_flit_pkg::link_t                in_link,
  input  logic [noc_topo_pkg::num_ports-1:0] grant,     // one bit per output arbiter
  output logic                               in_ready,
  output noc_flit_pkg::link_t                held,
  output logic [noc_topo_pkg::num_ports-1:0] route_req
);

  logic                               hold_valid;
  noc_flit_pkg::flit_t                hold_flit;
  logic [noc_topo_pkg::num_ports-1:0] dir;
  logic                               leaving;

  assign leaving  = |(grant & route_req);     // buffered flit goes out this edge
  assign in_ready = !hold_valid || leaving;   // empty, or emptying right now

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      hold_valid <= 1'b0;
    end else if (in_ready) begin
      hold_valid <= in_link.valid;
    end
  end

  always_ff @(posedge clk) begin
    if (in_ready && in_link.valid) begin
      hold_flit <= in_link.flit;
    end
  end

  // dimension order: settle x first, then y
  always_comb begin
    dir = '0;
    if (hold_flit.dst_x == x_loc && hold_flit.dst_y == y_loc) begin
      dir[noc_topo_pkg::port_pe] = 1'b1;
    end else if (hold_flit.dst_x > x_loc) begin
      dir[noc_topo_pkg::port_east] = 1'b1;
    end else if (hold_flit.dst_x < x_loc) begin
      dir[noc_topo_pkg::port_west] = 1'b1;
    end else if (hold_flit.dst_y > y_loc) begin
      dir[noc_topo_pkg::port_north] = 1'b1;
    end else begin
      dir[noc_topo_pkg::port_south] = 1'b1;
    end
  end

  assign route_req = hold_valid ? dir : '0;

  assign held.valid = hold_valid;
  assign held.flit  = hold_flit;

endmodule

/* rtl/noc_topo_pkg.sv */
package noc_topo_pkg;

  localparam int mesh_dim  = 4;
  localparam int num_nodes = mesh_dim * mesh_dim;
  localparam int num_ports = 5;

  // direction indices, also the bit order of route requests and grants
  localparam int port_pe    = 0;
  localparam int port_east  = 1;
  localparam int port_west  = 2;
  localparam int port_north = 3;
  localparam int port_south = 4;

  function automatic logic [noc_flit_pkg::coord_w-1:0] node_x(input int node);
    int x;
    x = node % mesh_dim;
    return x[noc_flit_pkg::coord_w-1:0];
  endfunction

  // node 0 is the top left corner, y counts down as the index grows
  // so one step north is index minus mesh_dim
  function automatic logic [noc_flit_pkg::coord_w-1:0] node_y(input int node);
    int y;
    y = mesh_dim - 1 - node / mesh_dim;
    return y[noc_flit_pkg::coord_w-1:0];
  endfunction

endpackage

/* rtl/noc_flit_pkg.sv */
package noc_flit_pkg;

  localparam int coord_w   = 2;   // one mesh coordinate
  localparam int payload_w = 28;

  // destination first, so x and y sit in the top four bits of the word
  typedef struct packed {
    logic [coord_w-1:0]   dst_x;
    logic [coord_w-1:0]   dst_y;
    logic [payload_w-1:0] payload;
  } flit_t;

  // forward half of a link, ready runs the other way
  typedef struct packed {
    logic  valid;
    flit_t flit;
  } link_t;

endpackage
